// ==== rtl/lmem_consts.svh ====
// Local memory bridge constants
// Bank count, bus widths, read pipe depth and reset chain length

`ifndef LMEM_CONSTS_SVH
`define LMEM_CONSTS_SVH

// Number of independent memory banks
`define LMEM_NUM_BANKS        2

// Avalon-MM bus widths, address counts words
`define LMEM_ADDR_W           16
`define LMEM_DATA_W           64
`define LMEM_BE_W             (`LMEM_DATA_W / 8)
`define LMEM_BURST_W          4

// Pipeline and reset timing
`define LMEM_RDATA_PIPE_DEPTH 2
`define LMEM_RST_SYNC_LEN     2

`endif

// ==== rtl/lmem_pkg.sv ====
// Local memory bridge types
// Command opcode enum, command struct and read response struct

`default_nettype none

`include "lmem_consts.svh"

package lmem_pkg;

   // ============================================================
   // Command opcodes
   // ============================================================

   typedef enum logic [1:0]
   {
      LMEM_OP_IDLE  = 2'd0,
      LMEM_OP_READ  = 2'd1,
      LMEM_OP_WRITE = 2'd2
   } lmem_op_e;

   // ============================================================
   // Bus payloads
   // ============================================================

   // One Avalon-MM command beat, host or memory side
   typedef struct packed
   {
      lmem_op_e                 op;
      logic [`LMEM_ADDR_W-1:0]  address;
      logic [`LMEM_BURST_W-1:0] burstcount;
      logic [`LMEM_DATA_W-1:0]  writedata;
      logic [`LMEM_BE_W-1:0]    byteenable;
   } lmem_cmd_t;

   // Read data beat, valid plays the role of readdatavalid
   typedef struct packed
   {
      logic                     valid;
      logic [`LMEM_DATA_W-1:0]  data;
   } lmem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/lmem_cmd_pipe.sv ====
// Command pipeline register for one memory bank
// One-entry Avalon-MM stage with waitrequest back-pressure
// Holding assertion on the memory side command

`default_nettype none

`include "lmem_consts.svh"

module lmem_cmd_pipe
(
   input  logic                Clk_100,
   input  logic                rst_n,
   input  logic                bank_rst,
   input  lmem_pkg::lmem_cmd_t host_cmd,
   output logic                host_waitrequest,
   output lmem_pkg::lmem_cmd_t mem_cmd,
   input  logic                mem_waitrequest
);

   import lmem_pkg::*;

   lmem_op_e                 op_q;
   logic [`LMEM_ADDR_W-1:0]  addr_q;
   logic [`LMEM_BURST_W-1:0] burst_q;
   logic [`LMEM_DATA_W-1:0]  wdata_q;
   logic [`LMEM_BE_W-1:0]    be_q;

   logic full;
   logic accept;
   logic drain;

   // Register occupied, memory taking it, host handing a new one over
   assign full             = (op_q != LMEM_OP_IDLE);
   assign drain            = full & ~mem_waitrequest;
   assign host_waitrequest = bank_rst | (full & mem_waitrequest);
   assign accept           = (host_cmd.op != LMEM_OP_IDLE) & ~host_waitrequest;

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         op_q <= LMEM_OP_IDLE;
      end
      else if (bank_rst)
      begin
         op_q <= LMEM_OP_IDLE;
      end
      else if (accept)
      begin
         op_q <= host_cmd.op;
      end
      else if (drain)
      begin
         op_q <= LMEM_OP_IDLE;
      end
   end

   // Payload only moves on a new command
   always_ff @(posedge Clk_100)
   begin
      if (accept)
      begin
         addr_q  <= host_cmd.address;
         burst_q <= host_cmd.burstcount;
         wdata_q <= host_cmd.writedata;
         be_q    <= host_cmd.byteenable;
      end
   end

   always_comb
   begin
      mem_cmd.op         = op_q;
      mem_cmd.address    = addr_q;
      mem_cmd.burstcount = burst_q;
      mem_cmd.writedata  = wdata_q;
      mem_cmd.byteenable = be_q;
   end

   // Stalled command must not change under the memory controller
   a_cmd_hold : assert property (
      @(posedge Clk_100) disable iff (!rst_n || bank_rst)
      (mem_waitrequest && (mem_cmd.op != LMEM_OP_IDLE)) |=> $stable(mem_cmd))
      else $error("mem_cmd changed while mem_waitrequest was high");

endmodule

`default_nettype wire

// ==== rtl/lmem_rdata_pipe.sv ====
// Read data pipe for one memory bank
// Fixed-depth shift stages, no back-pressure

`default_nettype none

`include "lmem_consts.svh"

module lmem_rdata_pipe
(
   input  logic                Clk_100,
   input  logic                rst_n,
   input  logic                bank_rst,
   input  lmem_pkg::lmem_rsp_t mem_rsp,
   output lmem_pkg::lmem_rsp_t host_rsp
);

   localparam int DEPTH = `LMEM_RDATA_PIPE_DEPTH;

   logic [DEPTH-1:0]                   valid_q;
   logic [DEPTH-1:0][`LMEM_DATA_W-1:0] data_q;

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= '0;
      end
      else if (bank_rst)
      begin
         valid_q <= '0;
      end
      else
      begin
         valid_q <= {valid_q[DEPTH-2:0], mem_rsp.valid};
      end
   end

   // Data shifts every cycle, valid qualifies it
   always_ff @(posedge Clk_100)
   begin
      data_q[0] <= mem_rsp.data;
      for (int i = 1; i < DEPTH; i++)
      begin
         data_q[i] <= data_q[i-1];
      end
   end

   assign host_rsp.valid = valid_q[DEPTH-1];
   assign host_rsp.data  = data_q[DEPTH-1];

   a_valid_known : assert property (
      @(posedge Clk_100) disable iff (!rst_n || bank_rst)
      !$isunknown(host_rsp.valid))
      else $error("host_rsp.valid unknown out of reset");

endmodule

`default_nettype wire

// ==== rtl/lmem_bank_bridge.sv ====
// Avalon-MM pipeline bridge for one memory bank
// Reset synchronizer with duplicated release stage
// Command pipe and read data pipe instances

`default_nettype none

`include "lmem_consts.svh"

module lmem_bank_bridge
(
   input  logic                Clk_100,
   input  logic                rst_n,
   input  lmem_pkg::lmem_cmd_t host_cmd,
   output logic                host_waitrequest,
   output lmem_pkg::lmem_rsp_t host_rsp,
   output lmem_pkg::lmem_cmd_t mem_cmd,
   input  logic                mem_waitrequest,
   input  lmem_pkg::lmem_rsp_t mem_rsp
);

   localparam int SYNC_LEN = `LMEM_RST_SYNC_LEN;

   // ============================================================
   // Bank reset
   // ============================================================

   // Asserts with rst_n, releases after the chain drains
   logic [SYNC_LEN-1:0] sync_q;
   logic                rst_stage_cmd;
   logic                rst_stage_rd;

   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sync_q <= '1;
      end
      else
      begin
         sync_q <= {sync_q[SYNC_LEN-2:0], 1'b0};
      end
   end

   // One copy per consumer to keep fanout local
   always_ff @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rst_stage_cmd <= 1'b1;
         rst_stage_rd  <= 1'b1;
      end
      else
      begin
         rst_stage_cmd <= sync_q[SYNC_LEN-1];
         rst_stage_rd  <= sync_q[SYNC_LEN-1];
      end
   end

   // ============================================================
   // Pipeline stages
   // ============================================================

   lmem_cmd_pipe u_cmd_pipe
   (
      .Clk_100          (Clk_100),
      .rst_n            (rst_n),
      .bank_rst         (rst_stage_cmd),
      .host_cmd         (host_cmd),
      .host_waitrequest (host_waitrequest),
      .mem_cmd          (mem_cmd),
      .mem_waitrequest  (mem_waitrequest)
   );

   lmem_rdata_pipe u_rdata_pipe
   (
      .Clk_100  (Clk_100),
      .rst_n    (rst_n),
      .bank_rst (rst_stage_rd),
      .mem_rsp  (mem_rsp),
      .host_rsp (host_rsp)
   );

endmodule

`default_nettype wire

// ==== rtl/lmem_bridge_top.sv ====
// Local memory bridge top level
// One independent pipeline bridge per memory bank

`default_nettype none

`include "lmem_consts.svh"

module lmem_bridge_top
(
   input  logic                Clk_100,
   input  logic                rst_n,

   // Host side
   input  lmem_pkg::lmem_cmd_t host_cmd         [`LMEM_NUM_BANKS],
   output logic                host_waitrequest [`LMEM_NUM_BANKS],
   output lmem_pkg::lmem_rsp_t host_rsp         [`LMEM_NUM_BANKS],

   // Memory controller side
   output lmem_pkg::lmem_cmd_t mem_cmd          [`LMEM_NUM_BANKS],
   input  logic                mem_waitrequest  [`LMEM_NUM_BANKS],
   input  lmem_pkg::lmem_rsp_t mem_rsp          [`LMEM_NUM_BANKS]
);

   // ============================================================
   // Bank bridges
   // ============================================================

   for (genvar b = 0; b < `LMEM_NUM_BANKS; b++)
   begin : g_bank
      lmem_bank_bridge u_bank_bridge
      (
         .Clk_100          (Clk_100),
         .rst_n            (rst_n),
         .host_cmd         (host_cmd[b]),
         .host_waitrequest (host_waitrequest[b]),
         .host_rsp         (host_rsp[b]),
         .mem_cmd          (mem_cmd[b]),
         .mem_waitrequest  (mem_waitrequest[b]),
         .mem_rsp          (mem_rsp[b])
      );
   end

endmodule

`default_nettype wire

// ==== tests/tb_lmem_mem_model.sv ====
// Memory controller model for one bank
// Random waitrequest, in-order read returns with random gaps
// Tracks accepted host commands against memory side transfers

`default_nettype none

`include "lmem_consts.svh"

module tb_lmem_mem_model
(
   input  logic                Clk_100,
   input  logic                rst_n,
   input  lmem_pkg::lmem_cmd_t host_cmd,
   input  logic                host_waitrequest,
   input  lmem_pkg::lmem_cmd_t mem_cmd,
   input  logic [3:0]          rand_bits,
   output logic                mem_waitrequest,
   output lmem_pkg::lmem_rsp_t mem_rsp,
   output logic                chk_valid,
   output lmem_pkg::lmem_cmd_t chk_got,
   output lmem_pkg::lmem_cmd_t chk_exp,
   output int                  cmd_pending
);

   timeunit 1ns;
   timeprecision 1ps;

   import lmem_pkg::*;

   localparam int AW = `LMEM_ADDR_W;
   localparam int BW = `LMEM_BURST_W;

   logic [`LMEM_DATA_W-1:0] mem [2**AW];
   logic [`LMEM_DATA_W-1:0] rd_q [$];
   lmem_cmd_t               host_q [$];
   lmem_cmd_t               exp_cmd;
   logic [AW-1:0]           addr;
   logic [BW-1:0]           wr_beat;

   // Power-up contents, unique for every address
   function automatic logic [`LMEM_DATA_W-1:0] fill_word(input logic [AW-1:0] a);
      return {a, ~a, a ^ 16'h3c3c, a + 16'h1234};
   endfunction

   initial
   begin
      mem_waitrequest = 1'b1;
      mem_rsp         = '0;
      chk_valid       = 1'b0;
      cmd_pending     = 0;
      wr_beat         = '0;
      for (int a = 0; a < 2**AW; a++)
         mem[a] = fill_word(AW'(a));
   end

   always @(posedge Clk_100 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mem_waitrequest <= 1'b1;
         mem_rsp         <= '0;
         chk_valid       <= 1'b0;
         cmd_pending     <= 0;
         wr_beat         = '0;
         host_q.delete();
         rd_q.delete();
      end
      else
      begin
         // Host side acceptance in issue order
         if (host_cmd.op != LMEM_OP_IDLE && !host_waitrequest)
            host_q.push_back(host_cmd);

         // Memory side transfer, paired with the oldest accepted command
         chk_valid <= 1'b0;
         if (mem_cmd.op != LMEM_OP_IDLE && !mem_waitrequest)
         begin
            exp_cmd = '0;
            if (host_q.size() > 0)
               exp_cmd = host_q.pop_front();
            chk_valid <= 1'b1;
            chk_got   <= mem_cmd;
            chk_exp   <= exp_cmd;
            if (mem_cmd.op == LMEM_OP_READ)
            begin
               // Data captured now so later writes cannot leak into it
               for (int i = 0; i < int'(mem_cmd.burstcount); i++)
               begin
                  addr = mem_cmd.address + AW'(i);
                  rd_q.push_back(mem[addr]);
               end
            end
            else if (mem_cmd.op == LMEM_OP_WRITE)
            begin
               addr = mem_cmd.address + AW'(wr_beat);
               for (int i = 0; i < `LMEM_BE_W; i++)
                  if (mem_cmd.byteenable[i])
                     mem[addr][8*i +: 8] = mem_cmd.writedata[8*i +: 8];
               if (wr_beat + BW'(1) == mem_cmd.burstcount)
                  wr_beat = '0;
               else
                  wr_beat = wr_beat + BW'(1);
            end
         end

         // Read beats leave in order, with random gaps
         mem_rsp.valid <= 1'b0;
         if (rd_q.size() > 0 && (rand_bits[2] || rand_bits[3]))
         begin
            mem_rsp.valid <= 1'b1;
            mem_rsp.data  <= rd_q.pop_front();
         end

         mem_waitrequest <= rand_bits[0] & rand_bits[1];
         cmd_pending     <= host_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_lmem_bridge.sv ====
// Testbench for the local memory bridge
// Clock, reset, LFSR stimulus, reference memory per bank
// Response monitor, compare task and run summary

`default_nettype none

`include "lmem_consts.svh"

module tb_lmem_bridge;

   timeunit 1ns;
   timeprecision 1ps;

   import lmem_pkg::*;

   localparam int NB      = `LMEM_NUM_BANKS;
   localparam int AW      = `LMEM_ADDR_W;
   localparam int BW      = `LMEM_BURST_W;
   localparam int TIMEOUT = 2000;

   logic        Clk_100   = 1'b0;
   logic [31:0] stim_lfsr = 32'he717;
   logic [31:0] mem_lfsr  = 32'he717;
   logic        rst_n;

   lmem_cmd_t  host_cmd         [NB];
   logic       host_waitrequest [NB];
   lmem_rsp_t  host_rsp         [NB];
   lmem_cmd_t  mem_cmd          [NB];
   logic       mem_waitrequest  [NB];
   lmem_rsp_t  mem_rsp          [NB];
   lmem_rsp_t  model_rsp        [NB];
   logic [3:0] rand_bits        [NB];
   logic       chk_valid        [NB];
   lmem_cmd_t  chk_got          [NB];
   lmem_cmd_t  chk_exp          [NB];
   int         cmd_pending      [NB];
   logic       inject;
   lmem_rsp_t  inject_rsp;
   logic       monitor_off;

   logic [`LMEM_DATA_W-1:0] ref_mem [NB][2**AW];
   logic [`LMEM_DATA_W-1:0] exp_buf [NB][64];
   int                      exp_wr  [NB];
   int                      exp_rd  [NB];
   int                      errors;
   int                      checks;

   always #2 Clk_100 = ~Clk_100;

   lmem_bridge_top UUT
   (
      .Clk_100          (Clk_100),
      .rst_n            (rst_n),
      .host_cmd         (host_cmd),
      .host_waitrequest (host_waitrequest),
      .host_rsp         (host_rsp),
      .mem_cmd          (mem_cmd),
      .mem_waitrequest  (mem_waitrequest),
      .mem_rsp          (mem_rsp)
   );

   for (genvar b = 0; b < NB; b++)
   begin : g_mem
      tb_lmem_mem_model u_mem_model
      (
         .Clk_100          (Clk_100),
         .rst_n            (rst_n),
         .host_cmd         (host_cmd[b]),
         .host_waitrequest (host_waitrequest[b]),
         .mem_cmd          (mem_cmd[b]),
         .rand_bits        (rand_bits[b]),
         .mem_waitrequest  (mem_waitrequest[b]),
         .mem_rsp          (model_rsp[b]),
         .chk_valid        (chk_valid[b]),
         .chk_got          (chk_got[b]),
         .chk_exp          (chk_exp[b]),
         .cmd_pending      (cmd_pending[b])
      );
   end

   // Bank 0 response can be overridden for the latency test
   always_comb
   begin
      for (int b = 0; b < NB; b++)
         mem_rsp[b] = model_rsp[b];
      if (inject)
         mem_rsp[0] = inject_rsp;
   end

   // ============================================================
   // Random numbers, checks and run end
   // ============================================================

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] rand_stim(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         stim_lfsr = lfsr_next(stim_lfsr);
         r = {r[62:0], stim_lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [`LMEM_DATA_W-1:0] fill_word(input logic [AW-1:0] a);
      return {a, ~a, a ^ 16'h3c3c, a + 16'h1234};
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("test %-18s %s (%0d errors)", name,
               (errors == err_before) ? "ok" : "failed", errors - err_before);
   endtask

   task automatic end_run();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   endtask

   // Model waitrequest and read gaps, 4 bits per bank per cycle
   always @(negedge Clk_100)
   begin
      for (int b = 0; b < NB; b++)
      begin
         for (int i = 0; i < 4; i++)
         begin
            mem_lfsr = lfsr_next(mem_lfsr);
            rand_bits[b][i] = mem_lfsr[0];
         end
      end
   end

   // Command order from the model, read data against the prediction
   always @(negedge Clk_100)
   begin
      for (int b = 0; b < NB; b++)
      begin
         if (chk_valid[b])
            check_value($sformatf("mem_cmd[%0d]", b), chk_got[b], chk_exp[b]);
         if (rst_n && !monitor_off && host_rsp[b].valid)
         begin
            if (exp_rd[b] == exp_wr[b])
            begin
               errors++;
               $display("bank %0d returned read data nobody asked for at %0t ns", b, $time);
            end
            else
            begin
               check_value($sformatf("host_rsp[%0d].data", b), host_rsp[b].data,
                           exp_buf[b][exp_rd[b] % 64]);
               exp_rd[b]++;
            end
         end
      end
   end

   // ============================================================
   // Host side transactions
   // ============================================================

   // Called on a falling edge, holds the beat until accepted
   task automatic send_beat(input int b, input lmem_cmd_t c);
      int t;
      t = 0;
      host_cmd[b] = c;
      while (host_waitrequest[b] && t < TIMEOUT)
      begin
         @(negedge Clk_100);
         t++;
      end
      if (t >= TIMEOUT)
      begin
         errors++;
         $display("bank %0d kept waitrequest high and never took a command", b);
         end_run();
      end
      else
      begin
         @(negedge Clk_100);
         host_cmd[b] = '0;
      end
   endtask

   task automatic write_burst(input int b, input logic [AW-1:0] addr, input int n,
                              input logic full_be);
      lmem_cmd_t     c;
      logic [AW-1:0] wa;
      for (int i = 0; i < n; i++)
      begin
         c.op         = LMEM_OP_WRITE;
         c.address    = addr;
         c.burstcount = BW'(n);
         c.writedata  = rand_stim(`LMEM_DATA_W);
         c.byteenable = full_be ? '1 : `LMEM_BE_W'(rand_stim(`LMEM_BE_W));
         wa = addr + AW'(i);
         for (int k = 0; k < `LMEM_BE_W; k++)
            if (c.byteenable[k])
               ref_mem[b][wa][8*k +: 8] = c.writedata[8*k +: 8];
         send_beat(b, c);
      end
   endtask

   task automatic read_burst(input int b, input logic [AW-1:0] addr, input int n);
      lmem_cmd_t     c;
      logic [AW-1:0] ra;
      c            = '0;
      c.op         = LMEM_OP_READ;
      c.address    = addr;
      c.burstcount = BW'(n);
      for (int i = 0; i < n; i++)
      begin
         ra = addr + AW'(i);
         exp_buf[b][exp_wr[b] % 64] = ref_mem[b][ra];
         exp_wr[b]++;
      end
      send_beat(b, c);
   endtask

   function automatic logic drained();
      logic d;
      d = 1'b1;
      for (int b = 0; b < NB; b++)
         if (exp_rd[b] != exp_wr[b] || cmd_pending[b] != 0)
            d = 1'b0;
      return d;
   endfunction

   task automatic wait_drained();
      int t;
      t = 0;
      while (!drained() && t < TIMEOUT)
      begin
         @(negedge Clk_100);
         t++;
      end
      if (t >= TIMEOUT)
      begin
         errors++;
         $display("read responses or memory commands still outstanding after timeout");
         end_run();
      end
   endtask

   // ============================================================
   // Test sequence
   // ============================================================

   initial
   begin
      int                      e0;
      int                      b;
      int                      n;
      logic [AW-1:0]           addr;
      logic [`LMEM_DATA_W-1:0] inj_data;

      rst_n       = 1'b0;
      inject      = 1'b0;
      inject_rsp  = '0;
      monitor_off = 1'b0;
      errors      = 0;
      checks      = 0;
      for (int k = 0; k < NB; k++)
      begin
         host_cmd[k]  = '0;
         rand_bits[k] = '0;
         exp_wr[k]    = 0;
         exp_rd[k]    = 0;
         for (int a = 0; a < 2**AW; a++)
            ref_mem[k][a] = fill_word(AW'(a));
      end

      // Reset held, then released through the bank synchronizer
      e0 = errors;
      for (int c = 0; c < 10; c++)
      begin
         @(negedge Clk_100);
         for (int k = 0; k < NB; k++)
         begin
            check_value("host_waitrequest", host_waitrequest[k], 1'b1);
            check_value("host_rsp.valid", host_rsp[k].valid, 1'b0);
            check_value("mem_cmd.op", mem_cmd[k].op, LMEM_OP_IDLE);
         end
      end
      rst_n = 1'b1;
      for (int c = 1; c <= `LMEM_RST_SYNC_LEN + 1; c++)
      begin
         @(negedge Clk_100);
         for (int k = 0; k < NB; k++)
         begin
            check_value("host_waitrequest", host_waitrequest[k], c <= `LMEM_RST_SYNC_LEN);
            check_value("host_rsp.valid", host_rsp[k].valid, 1'b0);
         end
      end
      report_test("reset", e0);

      e0 = errors;
      for (int k = 0; k < NB; k++)
      begin
         addr = AW'(rand_stim(8));
         write_burst(k, addr, 1, 1'b1);
         read_burst(k, addr, 1);
      end
      wait_drained();
      report_test("write read back", e0);

      e0 = errors;
      for (int k = 0; k < NB; k++)
      begin
         for (int i = 0; i < 4; i++)
         begin
            addr = AW'(rand_stim(8));
            write_burst(k, addr, 1, 1'b0);
            write_burst(k, addr, 1, 1'b0);
            read_burst(k, addr, 1);
         end
      end
      wait_drained();
      report_test("partial writes", e0);

      // Long mix on a small address window to force overlap
      e0 = errors;
      for (int i = 0; i < 300; i++)
      begin
         b    = int'(rand_stim(8) % NB);
         n    = int'(rand_stim(2)) + 1;
         addr = AW'(rand_stim(6));
         if (rand_stim(1) != 0)
            write_burst(b, addr, n, rand_stim(1) != 0);
         else
            read_burst(b, addr, n);
      end
      wait_drained();
      report_test("backpressure mix", e0);

      e0 = errors;
      addr = AW'(rand_stim(8));
      for (int k = 0; k < NB; k++)
         write_burst(k, addr, 1, 1'b1);
      for (int k = 0; k < NB; k++)
         read_burst(k, addr, 1);
      wait_drained();
      report_test("bank independence", e0);

      // One beat straight into bank 0, visible two cycles on
      e0 = errors;
      monitor_off      = 1'b1;
      inj_data         = rand_stim(`LMEM_DATA_W);
      inject_rsp.valid = 1'b1;
      inject_rsp.data  = inj_data;
      inject           = 1'b1;
      @(negedge Clk_100);
      inject     = 1'b0;
      inject_rsp = '0;
      check_value("host_rsp[0].valid", host_rsp[0].valid, 1'b0);
      @(negedge Clk_100);
      check_value("host_rsp[0].valid", host_rsp[0].valid, 1'b1);
      check_value("host_rsp[0].data", host_rsp[0].data, inj_data);
      @(negedge Clk_100);
      check_value("host_rsp[0].valid", host_rsp[0].valid, 1'b0);
      monitor_off = 1'b0;
      report_test("read latency", e0);

      end_run();
   end

endmodule

`default_nettype wire

// ==== lmem_bridge.f ====
+incdir+rtl
rtl/lmem_pkg.sv
rtl/lmem_cmd_pipe.sv
rtl/lmem_rdata_pipe.sv
rtl/lmem_bank_bridge.sv
rtl/lmem_bridge_top.sv
tests/tb_lmem_mem_model.sv
tests/tb_lmem_bridge.sv

// ==== Bender.yml ====
package:
  name: lmem_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lmem_pkg.sv
      - rtl/lmem_cmd_pipe.sv
      - rtl/lmem_rdata_pipe.sv
      - rtl/lmem_bank_bridge.sv
      - rtl/lmem_bridge_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_lmem_mem_model.sv
      - tests/tb_lmem_bridge.sv
